// ==== vstr_config.svh ====
`ifndef VSTR_CONFIG_SVH
`define VSTR_CONFIG_SVH

// bytes per data beat.
`define VSTR_DATA_BYTES 8

// input fifo slots, also the upstream credits after reset.
`define VSTR_FIFO_DEPTH 4

// credits granted by the memory side after reset.
`define VSTR_MEM_CREDITS 4

// byte address width.
`define VSTR_ADDR_W 32

// job length width, in bytes.
`define VSTR_LEN_W 16

`endif

// ==== vstr_pkg.sv ====
`default_nettype none

`include "vstr_config.svh"

package vstr_pkg;

    // one beat of payload.
    typedef logic [8*`VSTR_DATA_BYTES-1:0] data_t;

    // byte enables, one bit per beat byte.
    typedef logic [`VSTR_DATA_BYTES-1:0] strb_t;

    // byte address on the memory side.
    typedef logic [`VSTR_ADDR_W-1:0] addr_t;

    // job length in bytes; beat counts share this width.
    typedef logic [`VSTR_LEN_W-1:0] len_t;

endpackage

`default_nettype wire

// ==== vstr_ingress_fifo.sv ====
`default_nettype none

`include "vstr_config.svh"

module vstr_ingress_fifo (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            in_valid_i,
    input  vstr_pkg::data_t in_data_i,
    output logic            in_credit_o,
    output logic            out_valid_o,
    output vstr_pkg::data_t out_data_o,
    input  logic            out_ready_i
);

    import vstr_pkg::*;

    localparam int unsigned DEPTH = `VSTR_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    data_t            mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             push;
    logic             pop;
    logic             credit_q;

    // wraps at DEPTH, so the depth need not be a power of two.
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    assign push        = in_valid_i;                    // upstream only sends on a credit.
    assign pop         = out_valid_o & out_ready_i;
    assign out_valid_o = (cnt_q != '0);
    assign out_data_o  = mem_q[rd_ptr_q];
    assign in_credit_o = credit_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            credit_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            cnt_q    <= cnt_q + CNT_W'(push) - CNT_W'(pop);
            credit_q <= pop;                            // one credit back per pop.
        end
    end

    // storage, written beats show at the head next cycle.
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

    // a write into a full fifo means upstream sent without a credit.
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push |-> (cnt_q != CNT_W'(DEPTH)))
        else $error("ingress fifo written while full");

endmodule

`default_nettype wire

// ==== vstr_strb_gen.sv ====
`default_nettype none

`include "vstr_config.svh"

module vstr_strb_gen (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            start_i,
    input  vstr_pkg::len_t  len_i,
    input  logic            in_valid_i,
    input  vstr_pkg::data_t in_data_i,
    output logic            in_ready_o,
    output logic            out_valid_o,
    output vstr_pkg::data_t out_data_o,
    output vstr_pkg::strb_t out_strb_o,
    output logic            out_last_o,
    input  logic            out_ready_i
);

    import vstr_pkg::*;

    localparam int unsigned NB    = `VSTR_DATA_BYTES;
    localparam int unsigned LFT_W = $clog2(NB);

    len_t             tot_beats_q;
    len_t             beat_cnt_q;
    logic [LFT_W-1:0] lftovr_q;
    logic [LFT_W-1:0] len_lftovr;
    len_t             len_beats;
    logic             is_last;
    logic             xfer;
    strb_t            final_strb;

    assign len_lftovr = len_i[LFT_W-1:0];                          // bytes past the last full beat.
    assign len_beats  = (len_i >> LFT_W) + len_t'(|len_lftovr);    // rounded up.

    assign xfer    = in_valid_i & out_ready_i;
    assign is_last = (beat_cnt_q == tot_beats_q - 1'b1);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tot_beats_q <= '0;
            beat_cnt_q  <= '0;
            lftovr_q    <= '0;
        end else if (start_i) begin
            tot_beats_q <= len_beats;
            beat_cnt_q  <= '0;
            lftovr_q    <= len_lftovr;
        end else if (xfer) begin
            beat_cnt_q <= is_last ? '0 : beat_cnt_q + 1'b1;
        end
    end

    // only the low leftover bytes survive on the final beat.
    always_comb begin
        for (int i = 0; i < NB; i++) begin
            final_strb[i] = (LFT_W'(i) < lftovr_q);
        end
    end

    // handshake passes straight through.
    assign out_valid_o = in_valid_i;
    assign out_data_o  = in_data_i;
    assign in_ready_o  = out_ready_i;
    assign out_last_o  = is_last;
    assign out_strb_o  = (is_last && (lftovr_q != '0)) ? final_strb : '1;

    a_len_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_i |-> (len_i != '0))
        else $error("job started with zero length");

endmodule

`default_nettype wire

// ==== vstr_egress.sv ====
`default_nettype none

`include "vstr_config.svh"

module vstr_egress (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            start_i,
    input  vstr_pkg::addr_t base_addr_i,
    input  logic            in_valid_i,
    input  vstr_pkg::data_t in_data_i,
    input  vstr_pkg::strb_t in_strb_i,
    input  logic            in_last_i,
    output logic            in_ready_o,
    output logic            mem_valid_o,
    output vstr_pkg::addr_t mem_addr_o,
    output vstr_pkg::data_t mem_data_o,
    output vstr_pkg::strb_t mem_strb_o,
    output logic            mem_last_o,
    input  logic            mem_credit_i,
    output logic            busy_o,
    output logic            done_o
);

    import vstr_pkg::*;

    localparam int unsigned CREDITS = `VSTR_MEM_CREDITS;
    localparam int unsigned CRD_W   = $clog2(CREDITS + 1);

    logic [CRD_W-1:0] credit_q;
    logic             xfer;
    logic             last_issued;
    logic             valid_q;
    logic             last_q;
    logic             busy_q;
    logic             done_q;
    addr_t            addr_q;
    addr_t            mem_addr_q;
    data_t            mem_data_q;
    strb_t            mem_strb_q;

    assign in_ready_o  = (credit_q != '0);        // any credit left lets a beat in.
    assign xfer        = in_valid_i & in_ready_o;
    assign last_issued = valid_q & last_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credit_q <= CRD_W'(CREDITS);
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            credit_q <= credit_q - CRD_W'(xfer) + CRD_W'(mem_credit_i);
            valid_q  <= xfer;
            last_q   <= xfer & in_last_i;
            done_q   <= last_issued;              // a cycle after the last beat.
            if (start_i) begin
                busy_q <= 1'b1;
            end else if (last_issued) begin
                busy_q <= 1'b0;
            end
        end
    end

    // address walk and beat payload.
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            addr_q <= base_addr_i;
        end else if (xfer) begin
            addr_q <= addr_q + addr_t'(`VSTR_DATA_BYTES);
        end
        if (xfer) begin
            mem_addr_q <= addr_q;
            mem_data_q <= in_data_i;
            mem_strb_q <= in_strb_i;
        end
    end

    assign mem_valid_o = valid_q;
    assign mem_addr_o  = mem_addr_q;
    assign mem_data_o  = mem_data_q;
    assign mem_strb_o  = mem_strb_q;
    assign mem_last_o  = last_q;
    assign busy_o      = busy_q;
    assign done_o      = done_q;

    // memory must never return more credits than it was granted.
    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credit_q <= CRD_W'(CREDITS))
        else $error("memory credit count above grant");

endmodule

`default_nettype wire

// ==== vstr_top.sv ====
`default_nettype none

module vstr_top (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            start_i,
    input  vstr_pkg::addr_t base_addr_i,
    input  vstr_pkg::len_t  len_i,
    output logic            busy_o,
    output logic            done_o,
    input  logic            in_valid_i,
    input  vstr_pkg::data_t in_data_i,
    output logic            in_credit_o,
    output logic            mem_valid_o,
    output vstr_pkg::addr_t mem_addr_o,
    output vstr_pkg::data_t mem_data_o,
    output vstr_pkg::strb_t mem_strb_o,
    output logic            mem_last_o,
    input  logic            mem_credit_i
);

    import vstr_pkg::*;

    logic  fifo_valid;
    data_t fifo_data;
    logic  fifo_ready;
    logic  sg_valid;
    data_t sg_data;
    strb_t sg_strb;
    logic  sg_last;
    logic  sg_ready;

    vstr_ingress_fifo i_ingress (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_credit_o (in_credit_o),
        .out_valid_o (fifo_valid),
        .out_data_o  (fifo_data),
        .out_ready_i (fifo_ready)
    );

    vstr_strb_gen i_strb_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start_i),
        .len_i       (len_i),
        .in_valid_i  (fifo_valid),
        .in_data_i   (fifo_data),
        .in_ready_o  (fifo_ready),
        .out_valid_o (sg_valid),
        .out_data_o  (sg_data),
        .out_strb_o  (sg_strb),
        .out_last_o  (sg_last),
        .out_ready_i (sg_ready)
    );

    vstr_egress i_egress (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start_i),
        .base_addr_i  (base_addr_i),
        .in_valid_i   (sg_valid),
        .in_data_i    (sg_data),
        .in_strb_i    (sg_strb),
        .in_last_i    (sg_last),
        .in_ready_o   (sg_ready),
        .mem_valid_o  (mem_valid_o),
        .mem_addr_o   (mem_addr_o),
        .mem_data_o   (mem_data_o),
        .mem_strb_o   (mem_strb_o),
        .mem_last_o   (mem_last_o),
        .mem_credit_i (mem_credit_i),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

endmodule

`default_nettype wire

// ==== tb_vstr.sv ====
`default_nettype none

`include "vstr_config.svh"

module tb_vstr;

    timeunit 1ns;
    timeprecision 1ps;

    import vstr_pkg::*;

    localparam int NB      = `VSTR_DATA_BYTES;
    localparam int DEPTH   = `VSTR_FIFO_DEPTH;
    localparam int CREDITS = `VSTR_MEM_CREDITS;
    localparam int TIMEOUT = 2000;

    logic  clk_i, rst_ni, start_i, busy_o, done_o;
    logic  in_valid_i, in_credit_o, mem_valid_o, mem_last_o, mem_credit_i;
    addr_t base_addr_i, mem_addr_o;
    len_t  len_i;
    data_t in_data_i, mem_data_o;
    strb_t mem_strb_o;

    logic [31:0] rng;
    bit          run_en, job_req, mem_hold, busy_s, busy_at_done;
    addr_t       job_base;
    len_t        job_len;
    int          mem_max_delay, mem_wait, mem_owed, up_credits, max_inflight;
    int          credit_pulses, done_cnt, done_cyc, cyc;
    data_t       send_q[$];
    data_t       exp_data[$];
    int          sent_cyc[$];
    addr_t       rec_addr[$];
    data_t       rec_data[$];
    strb_t       rec_strb[$];
    logic        rec_last[$];
    int          rec_cyc[$];

    vstr_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
            else begin
                $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
                $display("Errors found");
                $fatal(1);
            end
    endtask

    // upstream sender, memory sink and monitor in one process.
    always @(negedge clk_i) begin
        if (run_en) begin
            cyc++;
            busy_s = busy_o;
            if (start_i) begin
                check_hex("busy_o", busy_o, 1);            // set the cycle after start.
            end
            if (mem_valid_o) begin
                check_hex("busy_o", busy_o, 1);
                rec_addr.push_back(mem_addr_o);
                rec_data.push_back(mem_data_o);
                rec_strb.push_back(mem_strb_o);
                rec_last.push_back(mem_last_o);
                rec_cyc.push_back(cyc);
                mem_owed++;
            end
            if (in_credit_o) begin
                up_credits++;
                credit_pulses++;
                assert (up_credits <= DEPTH)
                    else report_failure("upstream got more credits back than beats sent");
            end
            if (done_o) begin
                done_cnt++;
                done_cyc     = cyc;
                busy_at_done = busy_o;
            end
            start_i      = 1'b0;
            in_valid_i   = 1'b0;
            mem_credit_i = 1'b0;
            if (job_req) begin
                start_i     = 1'b1;
                base_addr_i = job_base;
                len_i       = job_len;
                job_req     = 1'b0;
            end else if (send_q.size() > 0 && up_credits > 0) begin
                in_valid_i = 1'b1;
                in_data_i  = send_q.pop_front();
                up_credits--;
                sent_cyc.push_back(cyc);
                if (DEPTH - up_credits > max_inflight) max_inflight = DEPTH - up_credits;
            end
            if (!mem_hold && mem_owed > 0) begin
                if (mem_wait > 0) begin
                    mem_wait--;
                end else begin
                    mem_credit_i = 1'b1;                    // hand one credit back.
                    mem_owed--;
                    mem_wait = int'(next_rand() % 32'(mem_max_delay + 1));
                end
            end
        end
    end

    task automatic start_job(input addr_t base, input int len);
        int    nb;
        data_t d;
        assert (!busy_s) else report_failure("job start requested while busy_o is high");
        nb = (len + NB - 1) / NB;
        exp_data.delete();
        sent_cyc.delete();
        rec_addr.delete();
        rec_data.delete();
        rec_strb.delete();
        rec_last.delete();
        rec_cyc.delete();
        credit_pulses = 0;
        done_cnt      = 0;
        max_inflight  = 0;
        for (int i = 0; i < nb; i++) begin
            d = {next_rand(), next_rand()};
            exp_data.push_back(d);
            send_q.push_back(d);
        end
        job_base = base;
        job_len  = len_t'(len);
        job_req  = 1'b1;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done_cnt == 0) begin
            @(posedge clk_i);
            n++;
            if (n > TIMEOUT) report_failure("timeout while waiting for done_o");
        end
    endtask

    task automatic wait_mem_idle();
        int n;
        n = 0;
        while (mem_owed > 0) begin
            @(posedge clk_i);
            n++;
            if (n > TIMEOUT) report_failure("timeout while memory credits were still owed");
        end
    endtask

    task automatic check_job(input addr_t base, input int len, input bit chk_lat);
        int          nb;
        int          rem;
        logic [63:0] exp_strb;
        nb  = (len + NB - 1) / NB;
        rem = len % NB;
        check_hex("mem beat count", rec_addr.size(), nb);
        for (int i = 0; i < nb; i++) begin
            exp_strb = (64'd1 << NB) - 1;
            if (i == nb - 1 && rem != 0) exp_strb = (64'd1 << rem) - 1;   // low leftover bytes.
            check_hex("mem_addr_o", rec_addr[i], base + addr_t'(i * NB));
            check_hex("mem_data_o", rec_data[i], exp_data[i]);
            check_hex("mem_strb_o", rec_strb[i], exp_strb);
            check_hex("mem_last_o", rec_last[i], (i == nb - 1));
            if (chk_lat) check_hex("mem_valid_o latency", rec_cyc[i] - sent_cyc[i], 2);
        end
        check_hex("in_credit_o pulses", credit_pulses, sent_cyc.size());
        check_hex("done_o pulses", done_cnt, 1);
        check_hex("done_o delay", done_cyc - rec_cyc[nb - 1], 1);
        check_hex("busy_o at done", busy_at_done, 0);
    endtask

    task automatic reset_and_full_beats();
        @(negedge clk_i);
        check_hex("busy_o", busy_o, 0);
        check_hex("done_o", done_o, 0);
        check_hex("mem_valid_o", mem_valid_o, 0);
        check_hex("in_credit_o", in_credit_o, 0);
        @(posedge clk_i);
        run_en = 1'b1;
        start_job(32'h0000_1000, 4 * NB);
        wait_done();
        check_job(32'h0000_1000, 4 * NB, 1'b0);
    endtask

    task automatic partial_final_beat();
        start_job(32'h0000_2000, 3 * NB + 5);
        wait_done();
        check_job(32'h0000_2000, 3 * NB + 5, 1'b0);
    endtask

    task automatic mem_backpressure();
        mem_hold = 1'b1;                                    // memory keeps its credits.
        start_job(32'h0000_3000, 8 * NB);
        for (int i = 0; i < 30; i++) @(posedge clk_i);
        assert (rec_addr.size() <= CREDITS)
            else report_failure("more beats issued than memory credits allow");
        mem_hold = 1'b0;
        wait_done();
        check_job(32'h0000_3000, 8 * NB, 1'b0);
    endtask

    task automatic input_credit_count();
        int n;
        mem_max_delay = 3;
        mem_hold      = 1'b1;                               // stalled egress lets the fifo fill.
        start_job(32'h0000_4000, 12 * NB);
        n = 0;
        while (max_inflight < DEPTH) begin
            @(posedge clk_i);
            n++;
            if (n > TIMEOUT) report_failure("upstream never had a full fifo of beats in flight");
        end
        mem_hold = 1'b0;
        wait_done();
        check_job(32'h0000_4000, 12 * NB, 1'b0);
    endtask

    task automatic two_cycle_latency();
        mem_max_delay = 0;
        wait_mem_idle();
        mem_wait = 0;                                       // credits go back at once.
        start_job(32'h0000_5000, 6 * NB);
        wait_done();
        check_job(32'h0000_5000, 6 * NB, 1'b1);
    endtask

    task automatic random_back_to_back();
        int    len;
        addr_t base;
        for (int j = 0; j < 20; j++) begin
            len           = int'(next_rand() % 32'd100) + 1;
            base          = next_rand() & ~addr_t'(NB - 1);    // beat aligned.
            mem_max_delay = int'(next_rand() % 32'd4);
            start_job(base, len);
            wait_done();
            check_job(base, len, 1'b0);
        end
    endtask

    initial begin
        rng           = 32'd50;
        run_en        = 1'b0;
        job_req       = 1'b0;
        mem_hold      = 1'b0;
        mem_max_delay = 0;
        mem_wait      = 0;
        mem_owed      = 0;
        up_credits    = DEPTH;
        cyc           = 0;
        busy_s        = 1'b0;
        rst_ni        = 1'b0;
        start_i       = 1'b0;
        base_addr_i   = '0;
        len_i         = '0;
        in_valid_i    = 1'b0;
        in_data_i     = '0;
        mem_credit_i  = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        reset_and_full_beats();
        partial_final_beat();
        mem_backpressure();
        input_credit_count();
        two_cycle_latency();
        random_back_to_back();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
vstr_pkg.sv
vstr_ingress_fifo.sv
vstr_strb_gen.sv
vstr_egress.sv
vstr_top.sv
tb_vstr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f vlog.f --top-module tb_vstr -o tb_vstr > build.log 2>&1 \
    && ./obj_dir/tb_vstr | tee sim.log \
    || { echo "build or simulation failed, see build.log"; exit 1; }
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
